// File: vlog.f
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_stage_id.sv
design/rv_execute.sv
design/rv_core_top.sv
verif/tb_clk_gen.sv
verif/rv_core_properties.sv
verif/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

// File: verif/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

  import rv_pipe_pkg::*;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] word;
  } pend_t;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic        stall;
  logic        flush;
  result_t     result;

  pend_t       exp_q[$];
  logic [31:0] mrf[32];
  logic [31:0] pc_model;
  logic        fetch_full;
  integer      seed;
  integer      mismatches;
  integer      failures;
  integer      n_instr;
  integer      n_wait;
  integer      cycles;
  string       test_name;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rv_core_top #(
    .RESET_PC (32'h100)
  ) i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .stall       (stall),
    .flush       (flush),
    .result      (result)
  );

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [19:0] imm,
                                        input logic [4:0] rd);
    return {imm, rd, opc};
  endfunction

  function automatic logic [4:0] rnd_reg();
    logic [31:0] r;
    r = $random(seed);
    return 5'(r % 31 + 1);
  endfunction

  // Any legal OP or OP-IMM word with random fields
  function automatic logic [31:0] rand_alu_word();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    r   = $random(seed);
    f3  = r[2:0];
    imm = r[31:20];
    f7  = ((f3 == 3'd0 || f3 == 3'd5) && r[4]) ? 7'h20 : 7'h00;
    if (r[3]) begin
      return enc_r(f7, rnd_reg(), rnd_reg(), f3, rnd_reg());
    end
    if (f3 == 3'd1) begin
      imm[11:5] = 7'h00;
    end else if (f3 == 3'd5) begin
      imm[11:5] = f7;
    end
    return enc_i(imm, rnd_reg(), f3, rnd_reg(), 7'h13);
  endfunction

  // RV32I semantics on the model register file
  task automatic model_exec(input logic [31:0] w, input logic [31:0] pc,
                            output logic [31:0] value, output logic trap);
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic        is_imm;
    opc    = w[6:0];
    f3     = w[14:12];
    f7     = w[31:25];
    a      = mrf[w[19:15]];
    is_imm = (opc == 7'h13);
    b      = is_imm ? {{20{w[31]}}, w[31:20]} : mrf[w[24:20]];
    value  = 32'h0;
    trap   = 1'b0;
    if (opc == 7'h37) begin
      value = {w[31:12], 12'h000};
    end else if (opc == 7'h17) begin
      value = pc + {w[31:12], 12'h000};
    end else if (opc == 7'h33 || is_imm) begin
      case (f3)
        3'd0: begin
          if (is_imm || f7 == 7'h00) value = a + b;
          else if (f7 == 7'h20) value = a - b;
          else trap = 1'b1;
        end
        3'd1: begin
          if (f7 == 7'h00) value = a << b[4:0];
          else trap = 1'b1;
        end
        3'd5: begin
          if (f7 == 7'h00) value = a >> b[4:0];
          else if (f7 == 7'h20) value = $unsigned($signed(a) >>> b[4:0]);
          else trap = 1'b1;
        end
        default: begin
          if (!is_imm && f7 != 7'h00) trap = 1'b1;
          else if (f3 == 3'd2) value = {31'd0, $signed(a) < $signed(b)};
          else if (f3 == 3'd3) value = {31'd0, a < b};
          else if (f3 == 3'd4) value = a ^ b;
          else if (f3 == 3'd6) value = a | b;
          else value = a & b;
        end
      endcase
    end else begin
      trap = 1'b1;
    end
    if (trap) value = 32'h0;
  endtask

  task automatic report_mismatch(input string field, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    mismatches++;
    $display("** Error [%s] %s expected %h actual %h", test_name, field, exp_v, act_v);
  endtask

  task automatic check_result();
    pend_t       p;
    logic [31:0] ev;
    logic        et;
    if (exp_q.size() == 0) begin
      failures++;
      $display("Error [%s] result valid with no instruction outstanding", test_name);
    end else begin
      p = exp_q.pop_front();
      model_exec(p.word, p.pc, ev, et);
      assert (result.pc == p.pc) else report_mismatch("pc", p.pc, result.pc);
      assert (result.rd == p.word[11:7])
        else report_mismatch("rd", 32'(p.word[11:7]), 32'(result.rd));
      assert (result.value == ev) else report_mismatch("value", ev, result.value);
      assert (result.trap == et) else report_mismatch("trap", 32'(et), 32'(result.trap));
      assert (result.trap_code == (et ? 2'd1 : 2'd0))
        else report_mismatch("trap_code", et ? 32'd1 : 32'd0, 32'(result.trap_code));
      if (!et && p.word[11:7] != 5'd0) begin
        mrf[p.word[11:7]] = ev;
      end
    end
  endtask

  // Reference pipeline bookkeeping, in acceptance order
  always @(posedge clk) begin
    if (rst_n) begin
      if (flush) begin
        // Word in fetch is dropped, the ID/EX entry moves on and completes
        if (fetch_full) begin
          void'(exp_q.pop_back());
        end
        fetch_full = 1'b0;
      end else if (!stall) begin
        fetch_full = instr_valid;
      end
      if (result.valid) begin
        check_result();
      end
      if (instr_valid && !stall && !flush) begin
        exp_q.push_back({pc_model, instr});
        pc_model = pc_model + 32'd4;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > 16 + 3 * (n_instr + n_wait) + 50) begin
      $display("Timeout: pipeline stopped producing results, %0d outstanding",
               exp_q.size());
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic issue(input logic [31:0] w);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= w;
    stall       <= 1'b0;
    flush       <= 1'b0;
    n_instr++;
  endtask

  task automatic stall_for(input integer k);
    repeat (k) begin
      @(posedge clk);
      instr_valid <= 1'b0;
      stall       <= 1'b1;
      flush       <= 1'b0;
      n_wait++;
    end
  endtask

  // Word offered together with flush is never accepted
  task automatic do_flush(input logic [31:0] w);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= w;
    stall       <= 1'b0;
    flush       <= 1'b1;
    n_instr++;
  endtask

  task automatic wait_drain();
    @(posedge clk);
    instr_valid <= 1'b0;
    stall       <= 1'b0;
    flush       <= 1'b0;
    n_wait++;
    @(negedge clk);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  initial begin
    logic [31:0] r;
    integer      i;
    instr_valid = 1'b0;
    instr       = 32'h0000_0013;
    stall       = 1'b0;
    flush       = 1'b0;
    seed        = 32'hf634_df01;
    mismatches  = 0;
    failures    = 0;
    n_instr     = 0;
    n_wait      = 0;
    cycles      = 0;
    pc_model    = 32'h100;
    fetch_full  = 1'b0;
    test_name   = "setup";
    for (i = 0; i < 32; i++) mrf[i] = 32'h0;
    wait (rst_n);

    for (i = 1; i < 32; i++) begin
      r = $random(seed);
      issue(enc_u(7'h37, r[31:12], 5'(i)));
      issue(enc_i(r[11:0], 5'(i), 3'd0, 5'(i), 7'h13));
    end
    wait_drain();

    test_name = "alu_ops";
    repeat (3) begin
      for (i = 0; i < 8; i++) begin
        r = $random(seed);
        issue(enc_r(7'h00, rnd_reg(), rnd_reg(), 3'(i), rnd_reg()));
        if (i == 0 || i == 5) issue(enc_r(7'h20, rnd_reg(), rnd_reg(), 3'(i), rnd_reg()));
        if (i == 1 || i == 5) begin
          issue(enc_i({7'h00, r[4:0]}, rnd_reg(), 3'(i), rnd_reg(), 7'h13));
          if (i == 5) issue(enc_i({7'h20, r[9:5]}, rnd_reg(), 3'(i), rnd_reg(), 7'h13));
        end else begin
          issue(enc_i(r[31:20], rnd_reg(), 3'(i), rnd_reg(), 7'h13));
        end
      end
    end
    // Largest shift amounts
    issue(enc_i({7'h00, 5'd31}, 5'd3, 3'd1, 5'd13, 7'h13));
    issue(enc_i({7'h20, 5'd31}, 5'd4, 3'd5, 5'd14, 7'h13));
    issue(enc_r(7'h20, 5'd14, 5'd5, 3'd5, 5'd15));
    wait_drain();

    test_name = "dependency";
    for (i = 20; i < 30; i++) begin
      r = $random(seed);
      if (i % 3 == 0) issue(enc_i(r[11:0], 5'(i), 3'd0, 5'(i + 1), 7'h13));
      else issue(enc_r(r[5] ? 7'h20 : 7'h00, rnd_reg(), 5'(i), 3'd0, 5'(i + 1)));
    end
    issue(enc_i(12'h7ff, 5'd3, 3'd0, 5'd0, 7'h13));
    issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd7));
    issue(enc_r(7'h00, 5'd0, 5'd7, 3'd6, 5'd0));
    issue(enc_r(7'h00, 5'd7, 5'd0, 3'd6, 5'd8));
    wait_drain();

    test_name = "invalid";
    issue(enc_i(12'h004, 5'd1, 3'd2, 5'd8, 7'h03));
    issue(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd9));
    issue(enc_r(7'h00, 5'd0, 5'd8, 3'd0, 5'd10));
    issue(enc_r(7'h00, 5'd0, 5'd9, 3'd0, 5'd11));
    wait_drain();

    test_name = "stall_flush";
    repeat (30) begin
      issue(rand_alu_word());
      r = $random(seed);
      if (r[1:0] == 2'd0) stall_for(1 + 32'(r[5:4]));
    end
    repeat (2) begin
      issue(rand_alu_word());
      issue(rand_alu_word());
      do_flush(rand_alu_word());
      r = $random(seed);
      issue(enc_u(7'h17, r[19:0], 5'd12));
      issue(enc_r(7'h00, 5'd0, 5'd12, 3'd0, 5'd16));
    end
    wait_drain();

    test_name = "idle";
    repeat (5) begin
      @(posedge clk);
      n_wait++;
    end

    $display("Errors: %0d value mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/rv_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties (
  input wire logic           clk,
  input wire logic           rst_n,
  input wire logic           instr_valid,
  input wire logic           stall,
  input wire logic           flush,
  input rv_pipe_pkg::result_t result
);

  // Pipeline is empty right after a reset cycle
  assert property (@(posedge clk) !rst_n |=> !result.valid)
    else $error("result valid set after reset");

  // Three stages, one cycle each
  assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid && !stall && !flush ##1 !stall && !flush ##1 !stall ##1 !stall
      |-> result.valid)
    else $error("result missing three cycles after an accepted instruction");

  assert property (@(posedge clk) disable iff (!rst_n) stall |-> !result.valid)
    else $error("result valid during stall");

  // Held result may not move while stall stays high
  assert property (@(posedge clk) disable iff (!rst_n) stall ##1 stall |-> $stable(result))
    else $error("result changed during stall");

  assert property (@(posedge clk) disable iff (!rst_n) !(instr_valid && stall))
    else $error("instr_valid presented during stall");

endmodule

bind rv_core_top rv_core_properties u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .instr_valid (instr_valid),
  .stall       (stall),
  .flush       (flush),
  .result      (result)
);

`default_nettype wire

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: design/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            instr_valid,
  input  wire logic [31:0]     instr,
  input  wire logic            stall,
  input  wire logic            flush,
  output rv_pipe_pkg::result_t result
);

  import rv_pipe_pkg::*;

  fetch_t  fetch;
  id_ex_t  id_ex;
  ex_fwd_t ex_fwd;
  wb_t     wb;

  rv_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .stall       (stall),
    .flush       (flush),
    .fetch       (fetch)
  );

  rv_stage_id u_stage_id (
    .clk    (clk),
    .rst_n  (rst_n),
    .stall  (stall),
    .flush  (flush),
    .fetch  (fetch),
    .ex_fwd (ex_fwd),
    .wb     (wb),
    .id_ex  (id_ex)
  );

  rv_execute u_execute (
    .clk    (clk),
    .rst_n  (rst_n),
    .stall  (stall),
    .id_ex  (id_ex),
    .result (result),
    .ex_fwd (ex_fwd),
    .wb     (wb)
  );

endmodule

`default_nettype wire

// File: design/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             stall,
  input  rv_pipe_pkg::id_ex_t   id_ex,
  output rv_pipe_pkg::result_t  result,
  output rv_pipe_pkg::ex_fwd_t  ex_fwd,
  output rv_pipe_pkg::wb_t      wb
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [4:0]  shamt;
  logic [31:0] alu_out;
  result_t     result_next;
  result_t     result_q;

  assign op_a  = id_ex.a_is_zero ? '0 :
                 id_ex.a_is_pc   ? id_ex.pc : id_ex.rs1_data;
  assign op_b  = id_ex.b_is_imm ? id_ex.imm : id_ex.rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (id_ex.alu_op)
      alu_add:  alu_out = op_a + op_b;
      alu_sub:  alu_out = op_a - op_b;
      alu_sll:  alu_out = op_a << shamt;
      alu_slt:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_out = {31'd0, op_a < op_b};
      alu_xor:  alu_out = op_a ^ op_b;
      alu_srl:  alu_out = op_a >> shamt;
      alu_sra:  alu_out = $unsigned($signed(op_a) >>> shamt);
      alu_or:   alu_out = op_a | op_b;
      alu_and:  alu_out = op_a & op_b;
      default:  alu_out = '0;
    endcase
  end

  always_comb begin
    result_next.valid     = id_ex.valid;
    result_next.pc        = id_ex.pc;
    result_next.rd        = id_ex.rd;
    result_next.value     = id_ex.trap ? '0 : alu_out;
    result_next.trap      = id_ex.trap;
    result_next.trap_code = id_ex.trap_code;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_q.valid <= 1'b0;
    end else if (!stall) begin
      result_q <= result_next;
    end
  end

  // Held entry is hidden during stall and shows again once it drops
  always_comb begin
    result       = result_q;
    result.valid = result_q.valid && !stall;
  end

  assign wb.en   = result.valid && !result.trap && (result.rd != 5'd0);
  assign wb.rd   = result.rd;
  assign wb.data = result.value;

  // Forward only entries that will write their rd
  assign ex_fwd.valid = id_ex.valid && id_ex.reg_write;
  assign ex_fwd.rd    = id_ex.rd;
  assign ex_fwd.value = alu_out;

endmodule

`default_nettype wire

// File: design/rv_stage_id.sv
`timescale 1ns/1ps
`default_nettype none

module rv_stage_id (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            stall,
  input  wire logic            flush,
  input  rv_pipe_pkg::fetch_t  fetch,
  input  rv_pipe_pkg::ex_fwd_t ex_fwd,
  input  rv_pipe_pkg::wb_t     wb,
  output rv_pipe_pkg::id_ex_t  id_ex
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  alu_op_t     dec_alu_op;
  logic        dec_a_is_pc;
  logic        dec_a_is_zero;
  logic        dec_b_is_imm;
  logic        dec_reg_write;
  logic        dec_invalid;
  logic [4:0]  dec_rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] dec_imm;
  logic [31:0] rf_rs1_data;
  logic [31:0] rf_rs2_data;
  id_ex_t      id_next;

  rv_decode u_decode (
    .instr     (fetch.instr),
    .alu_op    (dec_alu_op),
    .a_is_pc   (dec_a_is_pc),
    .a_is_zero (dec_a_is_zero),
    .b_is_imm  (dec_b_is_imm),
    .reg_write (dec_reg_write),
    .invalid   (dec_invalid),
    .rd        (dec_rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .imm       (dec_imm)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .wb       (wb),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data)
  );

  // EX result wins over the register file; valid already means it writes rd
  function automatic logic [31:0] fwd_sel(
    input logic [4:0]  idx,
    input logic [31:0] rf_data,
    input ex_fwd_t     fwd
  );
    if (fwd.valid && (idx != 5'd0) && (fwd.rd == idx)) begin
      return fwd.value;
    end
    return rf_data;
  endfunction

  always_comb begin
    id_next.valid     = fetch.valid;
    id_next.alu_op    = dec_alu_op;
    id_next.a_is_pc   = dec_a_is_pc;
    id_next.a_is_zero = dec_a_is_zero;
    id_next.b_is_imm  = dec_b_is_imm;
    // A trap never writes a register
    id_next.reg_write = dec_reg_write && !dec_invalid;
    id_next.trap      = dec_invalid;
    id_next.trap_code = dec_invalid ? trap_instr_invalid : trap_none;
    id_next.rd        = dec_rd;
    id_next.rs1_data  = fwd_sel(rs1, rf_rs1_data, ex_fwd);
    id_next.rs2_data  = fwd_sel(rs2, rf_rs2_data, ex_fwd);
    id_next.imm       = dec_imm;
    id_next.pc        = fetch.pc;
  end

  // ID/EX register, flush over stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
    end else if (flush) begin
      id_ex.valid <= 1'b0;
    end else if (!stall) begin
      id_ex <= id_next;
    end
  end

endmodule

`default_nettype wire

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic [4:0]    rs1,
  input  wire logic [4:0]    rs2,
  input  rv_pipe_pkg::wb_t   wb,
  output logic [31:0]        rs1_data,
  output logic [31:0]        rs2_data
);

  import rv_pipe_pkg::*;

  // x1..x31, x0 has no storage
  logic [31:1][31:0] regs;

  // Async read with bypass of a same-cycle write
  function automatic logic [31:0] read_port(
    input logic [4:0]        idx,
    input wb_t               w,
    input logic [31:1][31:0] file
  );
    if (idx == 5'd0) begin
      return '0;
    end else if (w.en && (w.rd == idx)) begin
      return w.data;
    end
    return file[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      regs <= '0;
    end else if (wb.en && (wb.rd != 5'd0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs1_data = read_port(rs1, wb, regs);
  assign rs2_data = read_port(rs2, wb, regs);

endmodule

`default_nettype wire

// File: design/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  rv_isa_pkg::rv_instr_t instr,
  output rv_isa_pkg::alu_op_t   alu_op,
  output logic                  a_is_pc,
  output logic                  a_is_zero,
  output logic                  b_is_imm,
  output logic                  reg_write,
  output logic                  invalid,
  output logic [4:0]            rd,
  output logic [4:0]            rs1,
  output logic [4:0]            rs2,
  output logic [31:0]           imm
);

  import rv_isa_pkg::*;

  // Register indices sit at the same place in every format
  assign rd  = instr.r.rd;
  assign rs1 = instr.r.rs1;
  assign rs2 = instr.r.rs2;

  always_comb begin
    logic is_imm;
    logic f7_zero;
    logic f7_is_alt;

    is_imm    = (instr.r.opcode == opc_op_imm);
    f7_zero   = (instr.r.funct7 == f7_base);
    f7_is_alt = (instr.r.funct7 == f7_alt);

    alu_op    = alu_add;
    a_is_pc   = 1'b0;
    a_is_zero = 1'b0;
    b_is_imm  = 1'b0;
    reg_write = 1'b0;
    invalid   = 1'b0;
    imm       = '0;

    case (instr.r.opcode)
      opc_op, opc_op_imm: begin
        reg_write = 1'b1;
        b_is_imm  = is_imm;
        // I view, sign extended; low five bits double as shamt
        imm       = {{20{instr.i.imm12[11]}}, instr.i.imm12};
        case (instr.r.funct3)
          f3_add_sub: begin
            // No funct7 in addi, the upper bits are immediate
            if (is_imm || f7_zero) begin
              alu_op = alu_add;
            end else if (f7_is_alt) begin
              alu_op = alu_sub;
            end else begin
              invalid = 1'b1;
            end
          end
          f3_sll: begin
            alu_op  = alu_sll;
            invalid = !f7_zero;
          end
          f3_slt: begin
            alu_op  = alu_slt;
            invalid = !is_imm && !f7_zero;
          end
          f3_sltu: begin
            alu_op  = alu_sltu;
            invalid = !is_imm && !f7_zero;
          end
          f3_xor: begin
            alu_op  = alu_xor;
            invalid = !is_imm && !f7_zero;
          end
          f3_srl_sra: begin
            if (f7_zero) begin
              alu_op = alu_srl;
            end else if (f7_is_alt) begin
              alu_op = alu_sra;
            end else begin
              invalid = 1'b1;
            end
          end
          f3_or: begin
            alu_op  = alu_or;
            invalid = !is_imm && !f7_zero;
          end
          f3_and: begin
            alu_op  = alu_and;
            invalid = !is_imm && !f7_zero;
          end
        endcase
      end
      opc_lui: begin
        // Result is 0 + imm
        a_is_zero = 1'b1;
        b_is_imm  = 1'b1;
        reg_write = 1'b1;
        imm       = {instr.u.imm20, 12'h000};
      end
      opc_auipc: begin
        a_is_pc   = 1'b1;
        b_is_imm  = 1'b1;
        reg_write = 1'b1;
        imm       = {instr.u.imm20, 12'h000};
      end
      default: begin
        invalid = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 instr_valid,
  input  wire logic [31:0]          instr,
  input  wire logic                 stall,
  input  wire logic                 flush,
  output rv_pipe_pkg::fetch_t       fetch
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  // Address given to the next accepted word
  logic [31:0] pc_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q        <= RESET_PC;
      fetch.valid <= 1'b0;
      fetch.pc    <= RESET_PC;
      fetch.instr <= i_nop;
    end else if (flush) begin
      // Drop the word in fetch, PC stays put
      fetch.valid <= 1'b0;
    end else if (!stall) begin
      if (instr_valid) begin
        fetch.valid <= 1'b1;
        fetch.pc    <= pc_q;
        fetch.instr <= instr;
        pc_q        <= pc_q + 32'd4;
      end else begin
        fetch.valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

  // Fetch register contents, 65 bits
  typedef struct packed {
    logic                  valid;
    logic [31:0]           pc;
    rv_isa_pkg::rv_instr_t instr;
  } fetch_t;

  typedef struct packed {
    logic                valid;
    rv_isa_pkg::alu_op_t alu_op;
    logic                a_is_pc;
    logic                a_is_zero;
    logic                b_is_imm;
    logic                reg_write;
    logic                trap;
    logic [1:0]          trap_code;
    logic [4:0]          rd;
    logic [31:0]         rs1_data;
    logic [31:0]         rs2_data;
    logic [31:0]         imm;
    logic [31:0]         pc;
  } id_ex_t;

  // Result of the entry now in EX, offered back to ID
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] value;
  } ex_fwd_t;

  typedef struct packed {
    logic        en;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] value;
    logic        trap;
    logic [1:0]  trap_code;
  } result_t;

endpackage

`default_nettype wire

// File: design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // Major opcodes handled by the core
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;

  // funct3 of the integer ALU group
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct7 values, alt selects sub and sra
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  localparam logic [1:0] trap_none          = 2'd0;
  localparam logic [1:0] trap_instr_invalid = 2'd1;

  // addi x0, x0, 0
  localparam logic [31:0] i_nop = 32'h0000_0013;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_fmt_t;

  // One instruction word, three views of it
  typedef union packed {
    rv_r_fmt_t r;
    rv_i_fmt_t i;
    rv_u_fmt_t u;
  } rv_instr_t;

endpackage

`default_nettype wire
